/* rfid_cmd_pkg.sv */
// command code type and the one-hot reader command codes
package rfid_cmd_pkg;

  // one bit per command, set by the command decoder before the first field bit
  typedef logic [12:0] cmd_t;

  // standard commands
  localparam cmd_t CMD_QUERYREP = 13'b0_0000_0000_0001;
  localparam cmd_t CMD_ACK      = 13'b0_0000_0000_0010;
  localparam cmd_t CMD_QUERY    = 13'b0_0000_0000_0100;
  localparam cmd_t CMD_QUERYADJ = 13'b0_0000_0000_1000;
  localparam cmd_t CMD_SELECT   = 13'b0_0000_0001_0000;
  localparam cmd_t CMD_NACK     = 13'b0_0000_0010_0000;
  localparam cmd_t CMD_REQRN    = 13'b0_0000_0100_0000;

  // memory access
  localparam cmd_t CMD_READ     = 13'b0_0000_1000_0000;
  localparam cmd_t CMD_WRITE    = 13'b0_0001_0000_0000;

  // custom commands, decoded upstream but carry no fields here
  localparam cmd_t CMD_TRNS     = 13'b0_0010_0000_0000;
  localparam cmd_t CMD_SAMPSENS = 13'b0_0100_0000_0000;
  localparam cmd_t CMD_SENSDATA = 13'b0_1000_0000_0000;
  localparam cmd_t CMD_BFCONST  = 13'b1_0000_0000_0000;

endpackage

/* rfid_field_pkg.sv */
// field widths, field types and fixed field lengths of the reader commands
package rfid_field_pkg;

  // handle and RN16 are both 16 bits
  localparam int HANDLE_W = 16;
  typedef logic [HANDLE_W-1:0] handle_t;

  // QUERY fields
  localparam int Q_W   = 4;
  localparam int SEL_W = 2;
  typedef logic [Q_W-1:0]   q_t;
  typedef logic [SEL_W-1:0] sel_t;

  // QUERYADJ up/down code
  localparam int UPDN_W = 3;
  typedef logic [UPDN_W-1:0] updn_t;

  // READ and WRITE fields
  localparam int BANK_W  = 2;
  localparam int PTR_W   = 8;
  localparam int WORDS_W = 8;
  localparam int DATA_W  = 16;
  typedef logic [BANK_W-1:0]  bank_t;
  typedef logic [PTR_W-1:0]   ptr_t;
  typedef logic [WORDS_W-1:0] words_t;
  typedef logic [DATA_W-1:0]  data_t;

  // bits skipped in front of sel (dr, m, trext)
  localparam int QUERY_LEAD_BITS    = 4;
  // bits skipped between sel and q (session, target)
  localparam int QUERY_MID_BITS     = 3;
  // session bits in front of the up/down code
  localparam int QUERYADJ_LEAD_BITS = 2;

  // one EBV block, extension bit plus 7 payload bits
  localparam int EBV_BYTE_BITS = 8;

  // field bit counters, wide enough for the 16 write data bits
  localparam int CNT_W = 5;
  typedef logic [CNT_W-1:0] bitcnt_t;

endpackage

/* ebv_ptr_decoder.sv */
// ebv_ptr_decoder: EBV-8 word pointer walk with extension bit check
module ebv_ptr_decoder (
  input  logic                 reset,
  input  logic                 bitinclk,
  input  logic                 bitin,
  input  logic                 bit_en,
  output rfid_field_pkg::ptr_t ptr,
  output logic                 ptr_done
);

  import rfid_field_pkg::*;

  // position inside the current EBV byte, 0 is the extension bit
  bitcnt_t byte_cnt;
  // extension bit of this byte was 0, payload is the pointer
  logic    last_byte;
  logic    byte_end;

  assign byte_end = (byte_cnt == bitcnt_t'(EBV_BYTE_BITS - 1));

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      byte_cnt  <= '0;
      last_byte <= 1'b0;
      ptr       <= '0;
      ptr_done  <= 1'b0;
    end else if (bit_en) begin
      if (byte_cnt == '0) begin
        // extension bit, 1 means another byte follows
        last_byte <= !bitin;
        byte_cnt  <= byte_cnt + 1'b1;
      end else begin
        // payload bits 6..0, ptr[7] is never written
        if (last_byte) begin
          ptr[EBV_BYTE_BITS - 1 - byte_cnt] <= bitin;
        end
        if (byte_end) begin
          byte_cnt <= '0;
          ptr_done <= last_byte;
        end else begin
          byte_cnt <= byte_cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* query_parser.sv */
// query_parser: sel, q and up/down field capture for QUERY and QUERYADJ
module query_parser (
  input  logic                  reset,
  input  logic                  bitinclk,
  input  logic                  bitin,
  input  rfid_cmd_pkg::cmd_t    packettype,
  output rfid_field_pkg::q_t    rx_q,
  output rfid_field_pkg::sel_t  sel,
  output rfid_field_pkg::updn_t rx_updn
);

  import rfid_cmd_pkg::*;
  import rfid_field_pkg::*;

  // lead skip, sel, middle skip, last field (q or up/down), idle
  typedef enum logic [2:0] {
    PH_LEAD,
    PH_SEL,
    PH_MID,
    PH_LAST,
    PH_DONE
  } phase_t;

  phase_t  phase;
  phase_t  next_phase;
  bitcnt_t cnt;
  bitcnt_t phase_bits;
  logic    phase_end;
  logic    is_query;
  logic    is_adj;

  assign is_query = (packettype == CMD_QUERY);
  assign is_adj   = (packettype == CMD_QUERYADJ);

  // length of the running phase
  always_comb begin
    case (phase)
      PH_LEAD: phase_bits = is_adj ? bitcnt_t'(QUERYADJ_LEAD_BITS) : bitcnt_t'(QUERY_LEAD_BITS);
      PH_SEL:  phase_bits = bitcnt_t'(SEL_W);
      PH_MID:  phase_bits = bitcnt_t'(QUERY_MID_BITS);
      PH_LAST: phase_bits = is_adj ? bitcnt_t'(UPDN_W) : bitcnt_t'(Q_W);
      default: phase_bits = '0;
    endcase
  end

  assign phase_end = (cnt == phase_bits - 1'b1);

  // QUERYADJ has no sel and no middle skip
  always_comb begin
    case (phase)
      PH_LEAD: next_phase = is_adj ? PH_LAST : PH_SEL;
      PH_SEL:  next_phase = PH_MID;
      PH_MID:  next_phase = PH_LAST;
      default: next_phase = PH_DONE;
    endcase
  end

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      phase   <= PH_LEAD;
      cnt     <= '0;
      rx_q    <= '0;
      sel     <= '0;
      rx_updn <= '0;
    end else if ((is_query || is_adj) && (phase != PH_DONE)) begin
      // fields come MSB first, bit lands in place on its own edge
      case (phase)
        PH_SEL:  sel[SEL_W - 1 - cnt] <= bitin;
        PH_LAST: begin
          if (is_adj) begin
            rx_updn[UPDN_W - 1 - cnt] <= bitin;
          end else begin
            rx_q[Q_W - 1 - cnt] <= bitin;
          end
        end
        default: ;
      endcase
      if (phase_end) begin
        phase <= next_phase;
        cnt   <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

/* access_parser.sv */
// access_parser: READ and WRITE field sequencer with write data unmasking
module access_parser (
  input  logic                    reset,
  input  logic                    bitinclk,
  input  logic                    bitin,
  input  rfid_cmd_pkg::cmd_t      packettype,
  input  rfid_field_pkg::handle_t currentrn,
  output rfid_field_pkg::bank_t   readwritebank,
  output rfid_field_pkg::ptr_t    readwriteptr,
  output rfid_field_pkg::words_t  readwords,
  output rfid_field_pkg::data_t   writedataout,
  output logic                    epc_data_ready,
  output logic                    fields_done
);

  import rfid_cmd_pkg::*;
  import rfid_field_pkg::*;

  // bank, EBV pointer, word count or data, then handle time
  typedef enum logic [1:0] {
    PH_BANK,
    PH_PTR,
    PH_TAIL,
    PH_DONE
  } phase_t;

  phase_t  phase;
  bitcnt_t cnt;
  bitcnt_t tail_last;
  logic    is_read;
  logic    is_write;
  logic    is_rw;
  logic    in_tail;
  logic    bit_en;
  logic    ptr_done;

  assign is_read  = (packettype == CMD_READ);
  assign is_write = (packettype == CMD_WRITE);
  assign is_rw    = is_read || is_write;

  // pointer bits go to the decoder until it reports the last payload bit
  assign bit_en = is_rw && (phase == PH_PTR) && !ptr_done;

  // first tail bit arrives while the phase register still says PH_PTR
  assign in_tail = (phase == PH_TAIL) || ((phase == PH_PTR) && ptr_done);

  // 8 word count bits for READ, 16 data bits for WRITE
  assign tail_last = is_read ? bitcnt_t'(WORDS_W - 1) : bitcnt_t'(DATA_W - 1);

  // handle matcher takes over from here
  assign fields_done = (phase == PH_DONE);

  // level stays up since packettype is held until the next reset
  assign epc_data_ready = fields_done && is_write;

  ebv_ptr_decoder i_ebv_ptr_decoder (
    .reset    (reset),
    .bitinclk (bitinclk),
    .bitin    (bitin),
    .bit_en   (bit_en),
    .ptr      (readwriteptr),
    .ptr_done (ptr_done)
  );

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      phase         <= PH_BANK;
      cnt           <= '0;
      readwritebank <= '0;
      readwords     <= '0;
      writedataout  <= '0;
    end else if (is_rw) begin
      case (phase)
        PH_BANK: begin
          readwritebank[BANK_W - 1 - cnt] <= bitin;
          if (cnt == bitcnt_t'(BANK_W - 1)) begin
            phase <= PH_PTR;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        PH_PTR, PH_TAIL: begin
          // cnt sits at 0 through the whole pointer phase
          if (in_tail) begin
            if (is_read) begin
              readwords[WORDS_W - 1 - cnt] <= bitin;
            end else begin
              // data is covered with the current RN16, bit for bit
              writedataout[DATA_W - 1 - cnt] <= bitin ^ currentrn[DATA_W - 1 - cnt];
            end
            if (cnt == tail_last) begin
              phase <= PH_DONE;
              cnt   <= '0;
            end else begin
              phase <= PH_TAIL;
              cnt   <= cnt + 1'b1;
            end
          end
        end
        default: ;
      endcase
    end
  end

endmodule

/* handle_matcher.sv */
// serial handle compare for ACK, REQRN, READ and WRITE
module handle_matcher (
  input  logic                    reset,
  input  logic                    bitinclk,
  input  logic                    bitin,
  input  rfid_cmd_pkg::cmd_t      packettype,
  input  rfid_field_pkg::handle_t currenthandle,
  input  logic                    fields_done,
  output logic                    handlematch
);

  import rfid_cmd_pkg::*;
  import rfid_field_pkg::*;

  // handle bit position, MSB first
  logic [$clog2(HANDLE_W)-1:0] pos;
  logic match_q;
  logic match_fail;
  logic cmp_en;
  logic bit_ok;
  logic last_bit;
  logic is_ack;

  assign is_ack = (packettype == CMD_ACK);

  // ACK and REQRN carry only the handle and READ or WRITE hand over with fields_done
  assign cmp_en = is_ack || (packettype == CMD_REQRN) || fields_done;

  // ~pos walks the handle from bit 15 down to bit 0
  assign bit_ok   = (bitin == currenthandle[~pos]);
  // counter saturates at all ones on the last handle bit
  assign last_bit = &pos;

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      pos        <= '0;
      match_q    <= 1'b0;
      match_fail <= 1'b0;
    end else if (cmp_en && !match_fail && !match_q) begin
      if (!bit_ok) begin
        // sticky fail ignores the later bits
        match_fail <= 1'b1;
      end else if (last_bit) begin
        match_q <= 1'b1;
      end else begin
        pos <= pos + 1'b1;
      end
    end
  end

  // ACK has no bit after the handle to clock the result out, so the
  // last bit is reported straight from bitin
  assign handlematch = match_q || (is_ack && last_bit && bit_ok && !match_fail);

endmodule

/* packet_parse.sv */
// packet_parse top level: query parser, access parser and handle matcher
module packet_parse (
  input  logic                    reset,
  input  logic                    bitinclk,
  input  logic                    bitin,
  input  rfid_cmd_pkg::cmd_t      packettype,
  input  rfid_field_pkg::handle_t currenthandle,
  input  rfid_field_pkg::handle_t currentrn,
  output logic                    handlematch,
  output rfid_field_pkg::q_t      rx_q,
  output rfid_field_pkg::sel_t    sel,
  output rfid_field_pkg::updn_t   rx_updn,
  output rfid_field_pkg::bank_t   readwritebank,
  output rfid_field_pkg::ptr_t    readwriteptr,
  output rfid_field_pkg::words_t  readwords,
  output rfid_field_pkg::data_t   writedataout,
  output logic                    epc_data_ready
);

  // READ/WRITE fields finished, handle bits follow
  logic fields_done;

  // QUERY and QUERYADJ fields
  query_parser i_query_parser (
    .reset      (reset),
    .bitinclk   (bitinclk),
    .bitin      (bitin),
    .packettype (packettype),
    .rx_q       (rx_q),
    .sel        (sel),
    .rx_updn    (rx_updn)
  );

  // bank, EBV pointer, word count or write data
  access_parser i_access_parser (
    .reset          (reset),
    .bitinclk       (bitinclk),
    .bitin          (bitin),
    .packettype     (packettype),
    .currentrn      (currentrn),
    .readwritebank  (readwritebank),
    .readwriteptr   (readwriteptr),
    .readwords      (readwords),
    .writedataout   (writedataout),
    .epc_data_ready (epc_data_ready),
    .fields_done    (fields_done)
  );

  // handle check for ACK, REQRN, READ and WRITE
  handle_matcher i_handle_matcher (
    .reset         (reset),
    .bitinclk      (bitinclk),
    .bitin         (bitin),
    .packettype    (packettype),
    .currenthandle (currenthandle),
    .fields_done   (fields_done),
    .handlematch   (handlematch)
  );

endmodule

/* tb_clock_gen.sv */
// testbench clock and reset generator, 100 ns bit clock with power-on and requested reset
module tb_clock_gen (
  input  logic reset_req,
  output logic bitinclk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  // power-on reset, held for the first two rising edges
  logic por;

  initial begin
    bitinclk = 1'b0;
    forever #50 bitinclk = ~bitinclk;
  end

  // released 10 ns after the edge, in step with the stimulus
  initial begin
    por = 1'b1;
    repeat (2) @(posedge bitinclk);
    #10;
    por = 1'b0;
  end

  // the testbench top pulses reset_req between commands
  assign reset = por || reset_req;

endmodule

/* tb_packet_parse.sv */
// testbench top for packet_parse: command stimulus, checking assertions, report and timeout
module tb_packet_parse;

  timeunit 1ns;
  timeprecision 100ps;

  import rfid_cmd_pkg::*;
  import rfid_field_pkg::*;

  // longest command is WRITE with two extended EBV bytes, handle and spare bits
  localparam int MAX_CMD_BITS = BANK_W + 3 * EBV_BYTE_BITS + DATA_W + HANDLE_W + 4;
  // reset pulse and settle cycles around each command
  localparam int CMD_OVERHEAD = 8;
  // query, queryadj, 2 ack, 6 read, 3 write, 2 reqrn
  localparam int NUM_CMDS     = 15;
  localparam int CYCLE_LIMIT  = NUM_CMDS * (MAX_CMD_BITS + CMD_OVERHEAD) + 100;

  logic    bitinclk;
  logic    reset;
  logic    reset_req;
  logic    bitin;
  cmd_t    packettype;
  handle_t currenthandle;
  handle_t currentrn;
  logic    handlematch;
  q_t      rx_q;
  sel_t    sel;
  updn_t   rx_updn;
  bank_t   readwritebank;
  ptr_t    readwriteptr;
  words_t  readwords;
  data_t   writedataout;
  logic    epc_data_ready;

  int          errors = 0;
  int          errors_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  logic [31:0] rand_state = 32'd25;
  // bits still to be sent, MSB of each field first
  logic        bit_q[$];

  tb_clock_gen i_clock_gen (
    .reset_req (reset_req),
    .bitinclk  (bitinclk),
    .reset     (reset)
  );

  packet_parse i_dut (
    .reset          (reset),
    .bitinclk       (bitinclk),
    .bitin          (bitin),
    .packettype     (packettype),
    .currenthandle  (currenthandle),
    .currentrn      (currentrn),
    .handlematch    (handlematch),
    .rx_q           (rx_q),
    .sel            (sel),
    .rx_updn        (rx_updn),
    .readwritebank  (readwritebank),
    .readwriteptr   (readwriteptr),
    .readwords      (readwords),
    .writedataout   (writedataout),
    .epc_data_ready (epc_data_ready)
  );

  // ready level and match flag hold until the next reset
  assert property (@(posedge bitinclk) disable iff (reset) epc_data_ready |=> epc_data_ready)
    else begin
      errors++;
      $display("epc_data_ready dropped without a reset");
    end
  assert property (@(posedge bitinclk) disable iff (reset) handlematch |=> handlematch)
    else begin
      errors++;
      $display("handlematch dropped without a reset");
    end

  // LCG, upper half is the better half
  function automatic logic [15:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state[31:16];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else begin
        errors++;
        $display("mismatch %s: expected 0x%0h, got 0x%0h", name, exp, got);
      end
  endtask

  task automatic check_outputs_clear(input logic with_match);
    check_value("rx_q", rx_q, 0);
    check_value("sel", sel, 0);
    check_value("rx_updn", rx_updn, 0);
    check_value("readwritebank", readwritebank, 0);
    check_value("readwriteptr", readwriteptr, 0);
    check_value("readwords", readwords, 0);
    check_value("writedataout", writedataout, 0);
    check_value("epc_data_ready", epc_data_ready, 0);
    if (with_match) begin
      check_value("handlematch", handlematch, 0);
    end
  endtask

  // every task starts and ends 10 ns after a rising edge
  task automatic drive_bit(input logic b);
    bitin = b;
    @(posedge bitinclk);
    #10;
  endtask

  task automatic send_bits(input int count);
    for (int i = 0; i < count; i++) begin
      drive_bit(bit_q.pop_front());
    end
  endtask

  task automatic push_field(input logic [31:0] value, input int width);
    for (int i = width - 1; i >= 0; i--) begin
      bit_q.push_back(value[i]);
    end
  endtask

  // extended bytes carry random payload, the final byte carries the pointer
  task automatic push_ebv(input int n_ext, input logic [6:0] ptr7);
    logic [15:0] r;
    for (int i = 0; i < n_ext; i++) begin
      r = next_rand();
      push_field({1'b1, r[6:0]}, EBV_BYTE_BITS);
    end
    push_field({1'b0, ptr7}, EBV_BYTE_BITS);
  endtask

  // a wrong handle differs from currenthandle in one random bit
  function automatic handle_t pick_handle(input logic match);
    logic [15:0] r;
    r = next_rand();
    return match ? currenthandle : currenthandle ^ (handle_t'(1) << r[3:0]);
  endfunction

  task automatic begin_test();
    errors_at_start = errors;
    reset_req  = 1'b1;
    bitin      = 1'b0;
    packettype = '0;
    bit_q.delete();
    repeat (2) @(posedge bitinclk);
    #10;
    reset_req = 1'b0;
    check_outputs_clear(1'b1);
    currenthandle = next_rand();
    currentrn     = next_rand();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %-12s ok", name);
    end else begin
      tests_failed++;
      $display("test %-12s failed with %0d errors", name, errors - errors_at_start);
    end
  endtask

  task automatic test_query();
    logic [15:0] r;
    begin_test();
    packettype = CMD_QUERY;
    r = next_rand();
    // lead bits, sel, middle bits, q
    push_field(r[3:0], QUERY_LEAD_BITS);
    push_field(r[5:4], SEL_W);
    push_field(r[8:6], QUERY_MID_BITS);
    push_field(r[12:9], Q_W);
    send_bits(bit_q.size());
    check_value("sel", sel, r[5:4]);
    check_value("rx_q", rx_q, r[12:9]);
    check_value("rx_updn", rx_updn, 0);
    end_test("query");
  endtask

  task automatic test_queryadj();
    logic [15:0] r;
    begin_test();
    packettype = CMD_QUERYADJ;
    r = next_rand();
    push_field(r[1:0], QUERYADJ_LEAD_BITS);
    push_field(r[4:2], UPDN_W);
    send_bits(bit_q.size());
    check_value("rx_updn", rx_updn, r[4:2]);
    check_value("sel", sel, 0);
    check_value("rx_q", rx_q, 0);
    end_test("queryadj");
  endtask

  // last handle bit is checked while it sits on bitin, before its edge
  task automatic test_ack(input logic match);
    handle_t     h;
    logic [15:0] r;
    begin_test();
    packettype = CMD_ACK;
    h = pick_handle(match);
    for (int i = HANDLE_W - 1; i >= 0; i--) begin
      bitin = h[i];
      #20;
      check_value("handlematch", handlematch, (i == 0) ? match : 1'b0);
      @(posedge bitinclk);
      #10;
    end
    check_value("handlematch", handlematch, match);
    r = next_rand();
    drive_bit(r[0]);
    check_value("handlematch", handlematch, match);
    end_test(match ? "ack_match" : "ack_wrong");
  endtask

  task automatic test_read(input int n_ext, input logic match);
    logic [15:0] r;
    logic [15:0] w;
    begin_test();
    packettype = CMD_READ;
    r = next_rand();
    w = next_rand();
    push_field(r[1:0], BANK_W);
    push_ebv(n_ext, r[8:2]);
    push_field(w[7:0], WORDS_W);
    push_field(pick_handle(match), HANDLE_W);
    send_bits(bit_q.size() - HANDLE_W);
    check_value("readwritebank", readwritebank, r[1:0]);
    check_value("readwriteptr", readwriteptr, {1'b0, r[8:2]});
    check_value("readwords", readwords, w[7:0]);
    check_value("handlematch", handlematch, 0);
    send_bits(HANDLE_W);
    check_value("handlematch", handlematch, match);
    check_value("writedataout", writedataout, 0);
    check_value("epc_data_ready", epc_data_ready, 0);
    end_test("read");
  endtask

  task automatic test_write(input int n_ext, input logic match);
    logic [15:0] r;
    data_t       d;
    begin_test();
    packettype = CMD_WRITE;
    r = next_rand();
    d = next_rand();
    push_field(r[1:0], BANK_W);
    push_ebv(n_ext, r[8:2]);
    push_field(d, DATA_W);
    push_field(pick_handle(match), HANDLE_W);
    // stop one bit short of the data end
    send_bits(BANK_W + (n_ext + 1) * EBV_BYTE_BITS + DATA_W - 1);
    check_value("epc_data_ready", epc_data_ready, 0);
    send_bits(1);
    check_value("epc_data_ready", epc_data_ready, 1);
    check_value("writedataout", writedataout, d ^ currentrn);
    check_value("readwritebank", readwritebank, r[1:0]);
    check_value("readwriteptr", readwriteptr, {1'b0, r[8:2]});
    send_bits(HANDLE_W);
    check_value("handlematch", handlematch, match);
    check_value("epc_data_ready", epc_data_ready, 1);
    check_value("readwords", readwords, 0);
    end_test("write");
  endtask

  task automatic test_reqrn(input logic match);
    logic [15:0] r;
    begin_test();
    packettype = CMD_REQRN;
    push_field(pick_handle(match), HANDLE_W);
    send_bits(HANDLE_W);
    check_value("handlematch", handlematch, match);
    // trailing bits after the handle
    r = next_rand();
    push_field(r[3:0], 4);
    send_bits(4);
    check_value("handlematch", handlematch, match);
    check_outputs_clear(1'b0);
    end_test(match ? "reqrn_match" : "reqrn_wrong");
  endtask

  always @(posedge bitinclk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    logic [15:0] r;
    reset_req     = 1'b0;
    bitin         = 1'b0;
    packettype    = '0;
    currenthandle = '0;
    currentrn     = '0;
    wait (reset === 1'b0);
    test_query();
    test_queryadj();
    test_ack(1'b1);
    test_ack(1'b0);
    // every EBV length with a right and a wrong handle
    for (int i = 0; i < 6; i++) begin
      test_read(i % 3, i < 3);
    end
    for (int i = 0; i < 3; i++) begin
      r = next_rand();
      test_write(r[7:0] % 3, i != 2);
    end
    test_reqrn(1'b1);
    test_reqrn(1'b0);
    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* files.f */
rfid_cmd_pkg.sv
rfid_field_pkg.sv
ebv_ptr_decoder.sv
query_parser.sv
access_parser.sv
handle_matcher.sv
packet_parse.sv
tb_clock_gen.sv
tb_packet_parse.sv

/* Bender.yml */
package:
  name: rfid_packet_parse

sources:
  - rfid_cmd_pkg.sv
  - rfid_field_pkg.sv
  - ebv_ptr_decoder.sv
  - query_parser.sv
  - access_parser.sv
  - handle_matcher.sv
  - packet_parse.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_packet_parse.sv
